//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f --top-module tb_nlc -o tb_nlc; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_nlc)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1

//--- src/nlc_calib_store.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_calib_store (
	input  logic clk,
	input  logic param_we,
	input  logic [nlc_pkg::CH_W-1:0] param_ch,
	input  logic [2:0] param_sel,
	input  logic [nlc_pkg::DATA_W-1:0] param_data,
	nlc_issue_if.store bus,
	output logic [nlc_pkg::DATA_W-1:0] operand_b
);
	import nlc_pkg::*;

	logic [DATA_W-1:0] mem [NUM_CH][NUM_WORDS];
	nlc_word_t sel;

	always_ff @(posedge clk) begin
		if (param_we)
			mem[param_ch][param_sel] <= param_data;
	end

	always_comb begin
		case (bus.step)
			STEP_CENTER: sel = W_NEG_MEAN;
			STEP_SCALE:  sel = W_RECIP_STDEV;
			default:     sel = nlc_word_t'(bus.ord); // Coefficient at current order
		endcase
	end

	assign operand_b = mem[bus.ch][sel];

endmodule

`default_nettype wire

//--- src/nlc_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// One operation per cycle from the sequencer
interface nlc_issue_if;
	import nlc_pkg::*;

	logic valid;
	nlc_step_t step;
	logic [ORD_W-1:0] ord;
	logic [CH_W-1:0] ch; // Also the result read address in ST_OUT

	modport seq (output valid, step, ord, ch);
	modport store (input step, ord, ch);
	modport work (input ch);
	modport pipe (input valid, step, ch);
endinterface

`default_nettype wire

//--- src/nlc_mac_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_mac_pipe (
	input  logic clk,
	input  logic rst,
	nlc_issue_if.pipe bus,
	input  logic [nlc_pkg::DATA_W-1:0] acc,
	input  logic [nlc_pkg::DATA_W-1:0] norm,
	input  logic [nlc_pkg::DATA_W-1:0] operand_b,
	nlc_wb_if.pipe wb
);
	import nlc_pkg::*;

	logic s1_valid;
	nlc_step_t s1_step;
	logic [CH_W-1:0] s1_ch;
	logic [DATA_W-1:0] s1_a;
	logic [DATA_W-1:0] s1_b;

	// Stage 1 operand capture
	always_ff @(posedge clk) begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= bus.valid;
		s1_step <= bus.step;
		s1_ch   <= bus.ch;
		s1_a    <= acc;
		s1_b    <= (bus.step == STEP_MUL) ? norm : operand_b;
	end

	// Stage 2 shared adder and multiplier
	always_ff @(posedge clk) begin
		if (rst)
			wb.valid <= 1'b0;
		else
			wb.valid <= s1_valid;
		wb.step <= s1_step;
		wb.ch   <= s1_ch;
		case (s1_step)
			STEP_SCALE, STEP_MUL: wb.data <= mul_q(s1_a, s1_b);
			default:              wb.data <= s1_a + s1_b; // Wraps
		endcase
	end

	// No operand read from a channel whose result is still in flight
	a_no_raw: assert property (@(posedge clk) disable iff (rst)
		bus.valid |-> !(s1_valid && s1_ch == bus.ch)
			&& !(wb.valid && wb.ch == bus.ch));

endmodule

`default_nettype wire

//--- src/nlc_pass_timer.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_pass_timer (
	input  logic clk,
	input  logic rst,
	input  logic go,
	output logic [nlc_pkg::CH_W-1:0] ch,
	output logic issuing,
	output logic pass_end
);
	import nlc_pkg::*;

	logic running;
	logic [PASS_CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			cnt     <= '0;
		end else if (go) begin
			running <= 1'b1;
			cnt     <= '0;
		end else if (pass_end) begin
			running <= 1'b0;
		end else if (running) begin
			cnt <= cnt + 1'b1;
		end
	end

	assign ch       = cnt[CH_W-1:0];
	assign issuing  = running && (cnt < PASS_CNT_W'(NUM_CH));
	assign pass_end = running && (cnt == PASS_CNT_W'(PASS_LEN - 1)); // Drain done

	// A new pass may only start on the last cycle of the old one
	a_go_idle: assert property (@(posedge clk) disable iff (rst)
		go |-> (!running || pass_end));

endmodule

`default_nettype wire

//--- src/nlc_pkg.sv
`default_nettype none

package nlc_pkg;

	localparam int NUM_CH     = 16;
	localparam int CH_W       = 4;
	localparam int DATA_W     = 32;
	localparam int FRAC_BITS  = 16;
	localparam int SAMPLE_W   = 21;
	localparam int POLY_ORDER = 5;
	localparam int ORD_W      = 3;
	localparam int NUM_WORDS  = 8;
	localparam int PIPE_DEPTH = 2;
	localparam int PASS_LEN   = NUM_CH + PIPE_DEPTH;
	localparam int PASS_CNT_W = $clog2(PASS_LEN);

	// Calibration word select, coefficients first
	typedef enum logic [2:0] {
		W_C0, W_C1, W_C2, W_C3, W_C4, W_C5,
		W_NEG_MEAN    = 3'd6,
		W_RECIP_STDEV = 3'd7
	} nlc_word_t;

	typedef enum logic [2:0] {STEP_CENTER, STEP_SCALE, STEP_ADD, STEP_MUL, STEP_OUT} nlc_step_t;

	typedef enum logic [2:0] {ST_IDLE, ST_CENTER, ST_SCALE, ST_ADD, ST_MUL, ST_OUT} nlc_state_t;

	// Q16.16 product, truncated toward minus infinity
	function automatic logic [DATA_W-1:0] mul_q(input logic signed [DATA_W-1:0] a,
		input logic signed [DATA_W-1:0] b);
		logic signed [2*DATA_W-1:0] p;
		p = a * b;
		return DATA_W'(p >>> FRAC_BITS);
	endfunction

	function automatic logic [DATA_W-1:0] sample_to_q(input logic [SAMPLE_W-1:0] s);
		logic [DATA_W-1:0] ext;
		ext = {{(DATA_W-SAMPLE_W){s[SAMPLE_W-1]}}, s};
		return ext << FRAC_BITS;
	endfunction

endpackage

`default_nettype wire

//--- src/nlc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic issuing,
	input  logic pass_end,
	input  logic [nlc_pkg::CH_W-1:0] ch,
	output logic go,
	nlc_issue_if.seq bus,
	output logic busy,
	output logic result_valid,
	output logic done
);
	import nlc_pkg::*;

	nlc_state_t state;
	logic [ORD_W-1:0] ord;
	logic compute;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			ord   <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (state == ST_IDLE) begin
				if (start) begin
					state <= ST_CENTER;
					ord   <= ORD_W'(POLY_ORDER);
				end
			end else if (pass_end) begin
				case (state)
					ST_CENTER: state <= ST_SCALE;
					ST_SCALE:  state <= ST_ADD;
					ST_ADD: begin
						if (ord == '0) begin
							state <= ST_OUT;
						end else begin
							state <= ST_MUL;
							ord   <= ord - 1'b1; // Horner step down
						end
					end
					ST_MUL: state <= ST_ADD;
					default: begin // Output pass drained
						state <= ST_IDLE;
						done  <= 1'b1;
					end
				endcase
			end
		end
	end

	// Next pass starts right behind the last one
	assign go = (state == ST_IDLE) ? start : (pass_end && state != ST_OUT);

	always_comb begin
		case (state)
			ST_CENTER: bus.step = STEP_CENTER;
			ST_SCALE:  bus.step = STEP_SCALE;
			ST_ADD:    bus.step = STEP_ADD;
			ST_MUL:    bus.step = STEP_MUL;
			default:   bus.step = STEP_OUT;
		endcase
	end

	assign compute      = (state != ST_IDLE) && (state != ST_OUT);
	assign bus.valid    = compute && issuing;
	assign bus.ord      = ord;
	assign bus.ch       = ch;
	assign result_valid = (state == ST_OUT) && issuing;
	assign busy         = (state != ST_IDLE);

	// Timer only runs inside a job
	a_timer_in_job: assert property (@(posedge clk) disable iff (rst)
		(issuing || pass_end) |-> busy);

endmodule

`default_nettype wire

//--- src/nlc_top.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_top (
	input  logic clk,
	input  logic rst,
	input  logic param_we,
	input  logic [nlc_pkg::CH_W-1:0] param_ch,
	input  logic [2:0] param_sel,
	input  logic [nlc_pkg::DATA_W-1:0] param_data,
	input  logic sample_we,
	input  logic [nlc_pkg::CH_W-1:0] sample_ch,
	input  logic [nlc_pkg::SAMPLE_W-1:0] sample_data,
	input  logic start,
	output logic busy,
	output logic result_valid,
	output logic [nlc_pkg::CH_W-1:0] result_ch,
	output logic [nlc_pkg::DATA_W-1:0] result_data,
	output logic done
);
	import nlc_pkg::*;

	logic go;
	logic issuing;
	logic pass_end;
	logic [CH_W-1:0] ch;
	logic [DATA_W-1:0] acc;
	logic [DATA_W-1:0] norm;
	logic [DATA_W-1:0] operand_b;

	nlc_issue_if issue_bus ();
	nlc_wb_if wb_bus ();

	nlc_sequencer i_seq (
		.clk, .rst, .start, .issuing, .pass_end, .ch, .go,
		.bus(issue_bus.seq), .busy, .result_valid, .done
	);

	nlc_pass_timer i_timer (.clk, .rst, .go, .ch, .issuing, .pass_end);

	nlc_calib_store i_calib (
		.clk, .param_we, .param_ch, .param_sel, .param_data,
		.bus(issue_bus.store), .operand_b
	);

	nlc_work_regs i_work (
		.clk, .sample_we, .sample_ch, .sample_data,
		.bus(issue_bus.work), .wb(wb_bus.work), .acc, .norm
	);

	nlc_mac_pipe i_pipe (
		.clk, .rst, .bus(issue_bus.pipe), .acc, .norm, .operand_b, .wb(wb_bus.pipe)
	);

	// Output pass reads the accumulators in channel order
	assign result_ch   = issue_bus.ch;
	assign result_data = acc;

endmodule

`default_nettype wire

//--- src/nlc_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface nlc_wb_if;
	import nlc_pkg::*;

	logic valid;
	nlc_step_t step;
	logic [CH_W-1:0] ch;
	logic [DATA_W-1:0] data;

	modport pipe (output valid, step, ch, data);
	modport work (input valid, step, ch, data);
endinterface

`default_nettype wire

//--- src/nlc_work_regs.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_work_regs (
	input  logic clk,
	input  logic sample_we,
	input  logic [nlc_pkg::CH_W-1:0] sample_ch,
	input  logic [nlc_pkg::SAMPLE_W-1:0] sample_data,
	nlc_issue_if.work bus,
	nlc_wb_if.work wb,
	output logic [nlc_pkg::DATA_W-1:0] acc,
	output logic [nlc_pkg::DATA_W-1:0] norm
);
	import nlc_pkg::*;

	logic [DATA_W-1:0] acc_mem [NUM_CH];
	logic [DATA_W-1:0] norm_mem [NUM_CH];

	always_ff @(posedge clk) begin
		if (sample_we)
			acc_mem[sample_ch] <= sample_to_q(sample_data);
		if (wb.valid) begin
			if (wb.step == STEP_SCALE) begin
				norm_mem[wb.ch] <= wb.data;
				acc_mem[wb.ch]  <= '0; // Horner starts from zero
			end else begin
				acc_mem[wb.ch] <= wb.data;
			end
		end
	end

	// Combinational read at the issue channel
	assign acc  = acc_mem[bus.ch];
	assign norm = norm_mem[bus.ch];

endmodule

`default_nettype wire

//--- tb/tb_nlc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nlc;
	import nlc_pkg::*;

	localparam int NUM_RUNS = 8;
	localparam int OUT_LAT  = 13 * PASS_LEN + 1; // Start edge to first result beat
	localparam int DONE_LAT = 14 * PASS_LEN + 1;
	localparam int LOAD_LEN = NUM_CH * (NUM_WORDS + 1);
	// Load, compute and quiet gap per run, plus half again
	localparam int MAX_CYCLES = NUM_RUNS * (LOAD_LEN + DONE_LAT + 2 * PASS_LEN) * 3 / 2;

	logic clk;
	logic rst;
	logic param_we;
	logic [CH_W-1:0] param_ch;
	logic [2:0] param_sel;
	logic [DATA_W-1:0] param_data;
	logic sample_we;
	logic [CH_W-1:0] sample_ch;
	logic [SAMPLE_W-1:0] sample_data;
	logic start;
	logic busy;
	logic result_valid;
	logic [CH_W-1:0] result_ch;
	logic [DATA_W-1:0] result_data;
	logic done;

	logic [DATA_W-1:0] calib [NUM_CH][NUM_WORDS];
	logic [SAMPLE_W-1:0] samples [NUM_CH];
	logic [DATA_W-1:0] expected [NUM_CH];
	logic [31:0] rng_state = 32'hec7ee48d;
	int cycles = 0;
	int start_cyc;
	int beats;
	int runs_done;
	logic armed; // A run is in progress and results are due

	nlc_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Signed value of about +-8.0 in Q16.16
	function automatic logic [31:0] small_rand();
		logic [31:0] r;
		r = xorshift();
		return {{12{r[19]}}, r[19:0]};
	endfunction

	function automatic logic [31:0] q_mul(input logic signed [31:0] a,
		input logic signed [31:0] b);
		logic signed [63:0] p;
		p = 64'(a) * 64'(b);
		return p[47:16];
	endfunction

	function automatic logic [31:0] widen_sample(input logic [SAMPLE_W-1:0] s);
		logic [31:0] ext;
		ext = {{(32-SAMPLE_W){s[SAMPLE_W-1]}}, s};
		return ext << FRAC_BITS;
	endfunction

	// Center, scale, then Horner from c5 down to c0
	function automatic logic [31:0] expected_result(input int ch);
		logic [31:0] acc;
		logic [31:0] norm;
		acc  = widen_sample(samples[ch]) + calib[ch][W_NEG_MEAN];
		norm = q_mul(acc, calib[ch][W_RECIP_STDEV]);
		acc  = '0;
		for (int k = POLY_ORDER; k >= 0; k--) begin
			acc = acc + calib[ch][k];
			if (k > 0)
				acc = q_mul(acc, norm);
		end
		return acc;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the runs did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$fatal(1, "timeout");
		end
	end

	// Result stream and done pulse against the expected values
	always @(posedge clk) begin
		if (!rst && result_valid) begin
			check_value("result_valid", 32'(armed), 32'd1);
			check_value("result_ch", 32'(result_ch), 32'(beats));
			check_value("result_data", result_data, expected[beats]);
			check_value("result beat cycle", 32'(cycles - start_cyc), 32'(OUT_LAT + beats));
			beats++;
		end
		if (!rst && done) begin
			check_value("done", 32'(armed), 32'd1);
			check_value("beats before done", 32'(beats), NUM_CH);
			check_value("done cycle", 32'(cycles - start_cyc), DONE_LAT);
			check_value("busy", 32'(busy), 32'd0);
			armed = 1'b0;
			runs_done++;
		end
	end

	task automatic load_channels(input bit with_calib);
		for (int ch = 0; ch < NUM_CH; ch++) begin
			if (with_calib) begin
				for (int w = 0; w < NUM_WORDS; w++) begin
					param_we   = 1'b1;
					param_ch   = CH_W'(ch);
					param_sel  = 3'(w);
					param_data = calib[ch][w];
					@(negedge clk);
				end
				param_we = 1'b0;
			end
			sample_we   = 1'b1;
			sample_ch   = CH_W'(ch);
			sample_data = samples[ch];
			@(negedge clk);
			sample_we = 1'b0;
		end
	endtask

	task automatic new_samples();
		logic [31:0] r;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			r = xorshift();
			samples[ch] = r[SAMPLE_W-1:0];
		end
	endtask

	task automatic run_engine(input bit extra_start);
		int n;
		n = runs_done;
		beats = 0;
		armed = 1'b1;
		start_cyc = cycles;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_value("busy", 32'(busy), 32'd1);
		if (extra_start) begin
			repeat (3 * PASS_LEN) @(negedge clk);
			start = 1'b1; // Ignored while busy
			@(negedge clk);
			start = 1'b0;
		end
		wait (runs_done == n + 1);
		repeat (PASS_LEN) @(negedge clk);
		check_value("done pulses", 32'(runs_done), 32'(n + 1));
		check_value("busy", 32'(busy), 32'd0);
	endtask

	initial begin
		logic [31:0] r;
		rst = 1'b1;
		param_we = 1'b0;
		param_ch = '0;
		param_sel = '0;
		param_data = '0;
		sample_we = 1'b0;
		sample_ch = '0;
		sample_data = '0;
		start = 1'b0;
		armed = 1'b0;
		beats = 0;
		runs_done = 0;
		start_cyc = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		repeat (5) begin
			@(negedge clk);
			check_value("busy", 32'(busy), 32'd0);
			check_value("result_valid", 32'(result_valid), 32'd0);
			check_value("done", 32'(done), 32'd0);
		end

		// Only c0 set, result is c0
		new_samples();
		for (int ch = 0; ch < NUM_CH; ch++) begin
			for (int w = 0; w < NUM_WORDS; w++)
				calib[ch][w] = '0;
			calib[ch][W_C0] = small_rand();
			expected[ch] = calib[ch][W_C0];
		end
		load_channels(1'b1);
		run_engine(1'b0);

		// Identity polynomial
		new_samples();
		for (int ch = 0; ch < NUM_CH; ch++) begin
			for (int w = 0; w < NUM_WORDS; w++)
				calib[ch][w] = '0;
			calib[ch][W_C1] = 32'h0001_0000;
			calib[ch][W_RECIP_STDEV] = 32'h0001_0000;
			expected[ch] = widen_sample(samples[ch]);
		end
		load_channels(1'b1);
		run_engine(1'b1);

		for (int run = 0; run < NUM_RUNS - 3; run++) begin
			new_samples();
			for (int ch = 0; ch < NUM_CH; ch++) begin
				for (int w = 0; w <= POLY_ORDER; w++)
					calib[ch][w] = small_rand();
				calib[ch][W_NEG_MEAN] = small_rand();
				r = xorshift();
				calib[ch][W_RECIP_STDEV] = {15'd0, r[16:0]}; // 0 to 2.0
			end
			for (int ch = 0; ch < NUM_CH; ch++)
				expected[ch] = expected_result(ch);
			load_channels(1'b1);
			run_engine(run % 2 == 0);
		end

		// Stored calibration reused, samples only
		new_samples();
		for (int ch = 0; ch < NUM_CH; ch++)
			expected[ch] = expected_result(ch);
		load_channels(1'b0);
		run_engine(1'b1);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
src/nlc_pkg.sv
src/nlc_issue_if.sv
src/nlc_wb_if.sv
src/nlc_sequencer.sv
src/nlc_pass_timer.sv
src/nlc_calib_store.sv
src/nlc_work_regs.sv
src/nlc_mac_pipe.sv
src/nlc_top.sv
tb/tb_nlc.sv
